// ==== fu_pkg.sv ====
package fu_pkg;

  // datapath and tag widths
  localparam int xlen  = 64;
  localparam int tag_w = 5;

  typedef logic [xlen-1:0]  xword_t;  // one operand or result word
  typedef logic [tag_w-1:0] tag_t;    // reservation station entry tag

  // integer ALU operations
  // codes above alu_cmple are illegal
  typedef enum logic [4:0] {
    alu_addq   = 5'h00,
    alu_subq   = 5'h01,
    alu_and    = 5'h02,
    alu_bic    = 5'h03,  // a and not b
    alu_bis    = 5'h04,  // a or b
    alu_ornot  = 5'h05,
    alu_xor    = 5'h06,
    alu_eqv    = 5'h07,  // a xor not b
    alu_srl    = 5'h08,
    alu_sll    = 5'h09,
    alu_sra    = 5'h0a,
    alu_cmpult = 5'h0b,
    alu_cmpeq  = 5'h0c,
    alu_cmpule = 5'h0d,
    alu_cmplt  = 5'h0e,  // signed
    alu_cmple  = 5'h0f   // signed
  } alu_func_t;

  // branch condition code
  // the low two bits pick the test and bit 2 inverts it
  typedef logic [2:0] br_func_t;

  localparam logic [1:0] br_lbc = 2'b00;  // bit 0 of operand clear
  localparam logic [1:0] br_eq  = 2'b01;  // operand is zero
  localparam logic [1:0] br_lt  = 2'b10;  // operand negative
  localparam logic [1:0] br_le  = 2'b11;  // negative or zero

  localparam int br_inv_bit = 2;  // set to negate the test

endpackage

// ==== alu.sv ====
`timescale 1ns/1ns

module alu (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              valid,
  input  fu_pkg::alu_func_t func,
  input  fu_pkg::xword_t    opa,
  input  fu_pkg::xword_t    opb,
  input  fu_pkg::tag_t      tag,
  output logic              done,
  output fu_pkg::xword_t    result,
  output fu_pkg::tag_t      done_tag
);

  fu_pkg::xword_t result_d;
  logic           func_legal;
  logic [5:0]     shamt;
  logic           lt_unsigned;
  logic           lt_signed;
  logic           eq;

  assign shamt       = opb[5:0];  // upper bits of opb ignored
  assign eq          = (opa == opb);
  assign lt_unsigned = (opa < opb);
  assign lt_signed   = ($signed(opa) < $signed(opb));

  always_comb begin
    func_legal = 1'b1;
    case (func)
      fu_pkg::alu_addq:   result_d = opa + opb;
      fu_pkg::alu_subq:   result_d = opa - opb;
      fu_pkg::alu_and:    result_d = opa & opb;
      fu_pkg::alu_bic:    result_d = opa & ~opb;
      fu_pkg::alu_bis:    result_d = opa | opb;
      fu_pkg::alu_ornot:  result_d = opa | ~opb;
      fu_pkg::alu_xor:    result_d = opa ^ opb;
      fu_pkg::alu_eqv:    result_d = opa ^ ~opb;
      fu_pkg::alu_srl:    result_d = opa >> shamt;
      fu_pkg::alu_sll:    result_d = opa << shamt;
      fu_pkg::alu_sra:    result_d = $signed(opa) >>> shamt;  // sign fill
      fu_pkg::alu_cmpult: result_d = fu_pkg::xword_t'(lt_unsigned);
      fu_pkg::alu_cmpeq:  result_d = fu_pkg::xword_t'(eq);
      fu_pkg::alu_cmpule: result_d = fu_pkg::xword_t'(lt_unsigned | eq);
      fu_pkg::alu_cmplt:  result_d = fu_pkg::xword_t'(lt_signed);
      fu_pkg::alu_cmple:  result_d = fu_pkg::xword_t'(lt_signed | eq);
      default: begin
        result_d   = '0;  // unknown opcode gives zero
        func_legal = 1'b0;
      end
    endcase
  end

  // done is the only control state here
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= valid;
    end
  end

  always_ff @(posedge clock) begin
    if (valid) begin
      result   <= result_d;
      done_tag <= tag;
    end
  end

  // the issue logic upstream must only send decoded ALU opcodes
  legal_func_a: assert property (
    @(posedge clock) disable iff (!rst_n)
    valid |-> func_legal
  );

endmodule

// ==== mult.sv ====
`timescale 1ns/1ns

module mult #(
  parameter int mult_stages = 4
) (
  input  logic           clock,
  input  logic           rst_n,
  input  logic           valid,
  input  fu_pkg::xword_t opa,
  input  fu_pkg::xword_t opb,
  input  fu_pkg::tag_t   tag,
  output logic           done,
  output fu_pkg::xword_t result,
  output fu_pkg::tag_t   done_tag
);

  localparam int chunk_w = fu_pkg::xlen / mult_stages;  // multiplier bits per stage

  if (!(mult_stages inside {1, 2, 4, 8})) begin : g_bad_stages
    $error("mult_stages must be 1, 2, 4 or 8");
  end

  // what each stage sees, stage 0 comes from the issue ports
  logic           valid_in  [mult_stages];
  fu_pkg::tag_t   tag_in    [mult_stages];
  fu_pkg::xword_t sum_in    [mult_stages];
  fu_pkg::xword_t mcand_in  [mult_stages];
  fu_pkg::xword_t mplier_in [mult_stages];
  fu_pkg::xword_t sum_d     [mult_stages];

  logic           valid_q  [mult_stages];
  fu_pkg::tag_t   tag_q    [mult_stages];
  fu_pkg::xword_t sum_q    [mult_stages];  // running low product
  fu_pkg::xword_t mcand_q  [mult_stages];  // multiplicand, pre-shifted
  fu_pkg::xword_t mplier_q [mult_stages];  // multiplier bits still to use

  always_comb begin
    valid_in[0]  = valid;
    tag_in[0]    = tag;
    sum_in[0]    = '0;
    mcand_in[0]  = opa;
    mplier_in[0] = opb;
    for (int i = 1; i < mult_stages; i++) begin
      valid_in[i]  = valid_q[i-1];
      tag_in[i]    = tag_q[i-1];
      sum_in[i]    = sum_q[i-1];
      mcand_in[i]  = mcand_q[i-1];
      mplier_in[i] = mplier_q[i-1];
    end
    // partial product of the low chunk, truncated to the low word
    for (int i = 0; i < mult_stages; i++) begin
      sum_d[i] = sum_in[i] + mcand_in[i] * fu_pkg::xword_t'(mplier_in[i][chunk_w-1:0]);
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < mult_stages; i++) begin
      if (!rst_n) begin
        valid_q[i] <= 1'b0;
      end else begin
        valid_q[i] <= valid_in[i];
      end
    end
  end

  // payload moves every cycle so each stage can carry its own op
  always_ff @(posedge clock) begin
    for (int i = 0; i < mult_stages; i++) begin
      tag_q[i] <= tag_in[i];
      sum_q[i] <= sum_d[i];
    end
    for (int i = 0; i < mult_stages - 1; i++) begin
      mcand_q[i]  <= mcand_in[i] << chunk_w;
      mplier_q[i] <= mplier_in[i] >> chunk_w;
    end
  end

  assign done     = valid_q[mult_stages-1];
  assign result   = sum_q[mult_stages-1];
  assign done_tag = tag_q[mult_stages-1];

  // fixed latency in both directions
  latency_a: assert property (
    @(posedge clock) disable iff (!rst_n)
    valid |-> ##mult_stages done
  );

  no_stray_done_a: assert property (
    @(posedge clock) disable iff (!rst_n)
    done |-> $past(valid, mult_stages)
  );

endmodule

// ==== brcond.sv ====
`timescale 1ns/1ns

module brcond (
  input  logic             clock,
  input  logic             rst_n,
  input  logic             valid,
  input  fu_pkg::br_func_t func,
  input  fu_pkg::xword_t   opa,
  input  logic             pred_taken,
  input  fu_pkg::tag_t     tag,
  output logic             done,
  output logic             taken,
  output logic             mispredict,
  output fu_pkg::tag_t     done_tag
);

  logic cond;
  logic taken_d;
  logic opa_zero;
  logic opa_neg;

  assign opa_zero = (opa == '0);
  assign opa_neg  = opa[fu_pkg::xlen-1];

  always_comb begin
    case (func[1:0])
      fu_pkg::br_lbc: cond = ~opa[0];
      fu_pkg::br_eq:  cond = opa_zero;
      fu_pkg::br_lt:  cond = opa_neg;
      default:        cond = opa_neg | opa_zero;  // br_le
    endcase
  end

  assign taken_d = cond ^ func[fu_pkg::br_inv_bit];

  // mispredict is qualified by valid so it never outlives done
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      done       <= 1'b0;
      mispredict <= 1'b0;
    end else begin
      done       <= valid;
      mispredict <= valid & (taken_d ^ pred_taken);
    end
  end

  always_ff @(posedge clock) begin
    if (valid) begin
      taken    <= taken_d;
      done_tag <= tag;
    end
  end

  mispredict_only_when_done_a: assert property (
    @(posedge clock) disable iff (!rst_n)
    mispredict |-> done
  );

endmodule

// ==== fu_bank.sv ====
`timescale 1ns/1ns

module fu_bank #(
  parameter int num_alu     = 2,
  parameter int mult_stages = 4
) (
  input  logic                             clock,
  input  logic                             rst_n,

  // alu issue, one lane per index
  input  logic              [num_alu-1:0]  alu_valid,
  input  fu_pkg::alu_func_t [num_alu-1:0]  alu_func,
  input  fu_pkg::xword_t    [num_alu-1:0]  alu_opa,
  input  fu_pkg::xword_t    [num_alu-1:0]  alu_opb,
  input  fu_pkg::tag_t      [num_alu-1:0]  alu_tag,

  // alu completion
  output logic              [num_alu-1:0]  alu_done,
  output fu_pkg::xword_t    [num_alu-1:0]  alu_result,
  output fu_pkg::tag_t      [num_alu-1:0]  alu_done_tag,

  // multiplier issue
  input  logic                             mult_valid,
  input  fu_pkg::xword_t                   mult_opa,
  input  fu_pkg::xword_t                   mult_opb,
  input  fu_pkg::tag_t                     mult_tag,

  // multiplier completion
  output logic                             mult_done,
  output fu_pkg::xword_t                   mult_result,
  output fu_pkg::tag_t                     mult_done_tag,

  // branch issue
  input  logic                             br_valid,
  input  fu_pkg::br_func_t                 br_func,
  input  fu_pkg::xword_t                   br_opa,
  input  logic                             br_pred_taken,
  input  fu_pkg::tag_t                     br_tag,

  // branch completion
  output logic                             br_done,
  output logic                             br_taken,
  output logic                             br_mispredict,
  output fu_pkg::tag_t                     br_done_tag
);

  // single cycle integer lanes
  for (genvar i = 0; i < num_alu; i++) begin : g_alu
    alu alu_0 (
      .clock    (clock),
      .rst_n    (rst_n),
      .valid    (alu_valid[i]),
      .func     (alu_func[i]),
      .opa      (alu_opa[i]),
      .opb      (alu_opb[i]),
      .tag      (alu_tag[i]),
      .done     (alu_done[i]),
      .result   (alu_result[i]),
      .done_tag (alu_done_tag[i])
    );
  end

  mult #(
    .mult_stages (mult_stages)
  ) mult_0 (
    .clock    (clock),
    .rst_n    (rst_n),
    .valid    (mult_valid),
    .opa      (mult_opa),
    .opb      (mult_opb),
    .tag      (mult_tag),
    .done     (mult_done),
    .result   (mult_result),
    .done_tag (mult_done_tag)
  );

  brcond brcond_0 (
    .clock      (clock),
    .rst_n      (rst_n),
    .valid      (br_valid),
    .func       (br_func),
    .opa        (br_opa),
    .pred_taken (br_pred_taken),
    .tag        (br_tag),
    .done       (br_done),
    .taken      (br_taken),
    .mispredict (br_mispredict),
    .done_tag   (br_done_tag)
  );

endmodule

// ==== tb_fu_bank.sv ====
`timescale 1ns/1ns

module tb_fu_bank;

  localparam int num_alu     = 2;
  localparam int mult_stages = 4;

  // phase lengths in issue cycles
  localparam int alu_reps   = 4;
  localparam int n_alu_rand = 16 * alu_reps;
  localparam int n_cmp      = 5 * 5 * 5;
  localparam int n_shift    = 3 * 5 * 5;
  localparam int n_mult     = 24;
  localparam int n_br       = 8 * 4 * 2;
  localparam int n_idle     = 8;
  localparam int n_mixed    = 40;
  localparam int n_ops      = n_alu_rand + n_cmp + n_shift + n_mult + n_br + n_idle + n_mixed;
  localparam int timeout_ns = (16 + n_ops + mult_stages + 100) * 100;

  localparam fu_pkg::xword_t corner_vals [5] = '{
    64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 64'h0, 64'h1, 64'h7fff_ffff_ffff_ffff
  };
  // the last two have bits above bit 5 set
  localparam fu_pkg::xword_t shift_amts [5] = '{
    64'd0, 64'd1, 64'd63, 64'h40, 64'hffff_ffff_ffff_ff41
  };
  localparam fu_pkg::alu_func_t cmp_ops [5] = '{
    fu_pkg::alu_cmpult, fu_pkg::alu_cmpeq, fu_pkg::alu_cmpule, fu_pkg::alu_cmplt, fu_pkg::alu_cmple
  };
  localparam fu_pkg::alu_func_t shift_ops [3] = '{
    fu_pkg::alu_srl, fu_pkg::alu_sll, fu_pkg::alu_sra
  };

  logic clock;
  logic rst_n;

  logic              [num_alu-1:0] alu_valid;
  fu_pkg::alu_func_t [num_alu-1:0] alu_func;
  fu_pkg::xword_t    [num_alu-1:0] alu_opa;
  fu_pkg::xword_t    [num_alu-1:0] alu_opb;
  fu_pkg::tag_t      [num_alu-1:0] alu_tag;
  logic              [num_alu-1:0] alu_done;
  fu_pkg::xword_t    [num_alu-1:0] alu_result;
  fu_pkg::tag_t      [num_alu-1:0] alu_done_tag;

  logic             mult_valid;
  fu_pkg::xword_t   mult_opa;
  fu_pkg::xword_t   mult_opb;
  fu_pkg::tag_t     mult_tag;
  logic             mult_done;
  fu_pkg::xword_t   mult_result;
  fu_pkg::tag_t     mult_done_tag;

  logic             br_valid;
  fu_pkg::br_func_t br_func;
  fu_pkg::xword_t   br_opa;
  logic             br_pred_taken;
  fu_pkg::tag_t     br_tag;
  logic             br_done;
  logic             br_taken;
  logic             br_mispredict;
  fu_pkg::tag_t     br_done_tag;

  integer       seed;
  fu_pkg::tag_t tag_seq;  // running tag, distinct for ops in flight

  // expected completions, built from inputs sampled at issue
  logic           [num_alu-1:0] exp_alu_v;
  fu_pkg::xword_t [num_alu-1:0] exp_alu_res;
  fu_pkg::tag_t   [num_alu-1:0] exp_alu_tag;
  logic           exp_mult_v   [mult_stages];
  fu_pkg::xword_t exp_mult_res [mult_stages];
  fu_pkg::tag_t   exp_mult_tag [mult_stages];
  logic           exp_br_v;
  logic           exp_br_taken;
  logic           exp_br_mis;
  fu_pkg::tag_t   exp_br_tag;

  fu_bank #(
    .num_alu     (num_alu),
    .mult_stages (mult_stages)
  ) i_fu_bank (.*);

  initial clock = 1'b0;
  always #50 clock = ~clock;

  function automatic fu_pkg::xword_t alu_expect(
    input fu_pkg::alu_func_t f,
    input fu_pkg::xword_t    a,
    input fu_pkg::xword_t    b
  );
    logic [5:0]     sh;
    logic           lt_s;
    fu_pkg::xword_t fill;
    sh   = b[5:0];
    lt_s = (a[63] != b[63]) ? a[63] : (a < b);  // signs differ, the negative one is smaller
    fill = a[63] ? ~({64{1'b1}} >> sh) : '0;   // vacated high bits for sra
    case (f)
      fu_pkg::alu_addq:   return a + b;
      fu_pkg::alu_subq:   return a - b;
      fu_pkg::alu_and:    return a & b;
      fu_pkg::alu_bic:    return a & ~b;
      fu_pkg::alu_bis:    return a | b;
      fu_pkg::alu_ornot:  return a | ~b;
      fu_pkg::alu_xor:    return a ^ b;
      fu_pkg::alu_eqv:    return ~(a ^ b);
      fu_pkg::alu_srl:    return a >> sh;
      fu_pkg::alu_sll:    return a << sh;
      fu_pkg::alu_sra:    return (a >> sh) | fill;
      fu_pkg::alu_cmpult: return {63'b0, a < b};
      fu_pkg::alu_cmpeq:  return {63'b0, a == b};
      fu_pkg::alu_cmpule: return {63'b0, a <= b};
      fu_pkg::alu_cmplt:  return {63'b0, lt_s};
      fu_pkg::alu_cmple:  return {63'b0, lt_s || (a == b)};
      default:            return '0;
    endcase
  endfunction

  function automatic logic br_expect(input fu_pkg::br_func_t f, input fu_pkg::xword_t a);
    logic c;
    case (f[1:0])
      fu_pkg::br_lbc: c = !a[0];
      fu_pkg::br_eq:  c = (a == '0);
      fu_pkg::br_lt:  c = a[63];
      default:        c = a[63] || (a == '0);
    endcase
    return c ^ f[fu_pkg::br_inv_bit];
  endfunction

  function automatic fu_pkg::xword_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic coin();
    integer r;
    r = $random(seed);
    return r[0];
  endfunction

  task automatic stop_with_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("** Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
    stop_with_failure();
  endtask

  task automatic next_drive_slot();
    @(posedge clock);
    #10;
  endtask

  task automatic drive_alu(
    input int                lane,
    input fu_pkg::alu_func_t f,
    input fu_pkg::xword_t    a,
    input fu_pkg::xword_t    b
  );
    alu_valid[lane] = 1'b1;
    alu_func[lane]  = f;
    alu_opa[lane]   = a;
    alu_opb[lane]   = b;
    alu_tag[lane]   = tag_seq;
    tag_seq++;
  endtask

  task automatic drive_mult(input fu_pkg::xword_t a, input fu_pkg::xword_t b);
    mult_valid = 1'b1;
    mult_opa   = a;
    mult_opb   = b;
    mult_tag   = tag_seq;
    tag_seq++;
  endtask

  task automatic drive_br(input fu_pkg::br_func_t f, input fu_pkg::xword_t a, input logic pred);
    br_valid      = 1'b1;
    br_func       = f;
    br_opa        = a;
    br_pred_taken = pred;
    br_tag        = tag_seq;
    tag_seq++;
  endtask

  // operands stay where they are
  task automatic clear_valids();
    alu_valid  = '0;
    mult_valid = 1'b0;
    br_valid   = 1'b0;
  endtask

  always @(posedge clock) begin
    if (!rst_n) begin
      exp_alu_v <= '0;
      exp_br_v  <= 1'b0;
      for (int i = 0; i < mult_stages; i++) exp_mult_v[i] <= 1'b0;
    end else begin
      exp_alu_v     <= alu_valid;
      exp_br_v      <= br_valid;
      exp_mult_v[0] <= mult_valid;
      for (int i = 1; i < mult_stages; i++) exp_mult_v[i] <= exp_mult_v[i-1];
    end
    for (int i = 0; i < num_alu; i++) begin
      exp_alu_res[i] <= alu_expect(alu_func[i], alu_opa[i], alu_opb[i]);
      exp_alu_tag[i] <= alu_tag[i];
    end
    exp_mult_res[0] <= mult_opa * mult_opb;  // low 64 bits only
    exp_mult_tag[0] <= mult_tag;
    for (int i = 1; i < mult_stages; i++) begin
      exp_mult_res[i] <= exp_mult_res[i-1];
      exp_mult_tag[i] <= exp_mult_tag[i-1];
    end
    exp_br_taken <= br_expect(br_func, br_opa);
    exp_br_mis   <= br_expect(br_func, br_opa) ^ br_pred_taken;
    exp_br_tag   <= br_tag;
  end

  // quiet outputs through reset and on the first edge after it
  reset_alu_a: assert property (@(posedge clock) !rst_n |=> alu_done == '0)
    else report_mismatch("alu_done", '0, $sampled(alu_done));
  reset_mult_a: assert property (@(posedge clock) !rst_n |=> !mult_done)
    else report_mismatch("mult_done", '0, $sampled(mult_done));
  reset_br_a: assert property (@(posedge clock) !rst_n |=> !br_done)
    else report_mismatch("br_done", '0, $sampled(br_done));

  for (genvar i = 0; i < num_alu; i++) begin : g_alu_check
    alu_done_a: assert property (@(posedge clock) disable iff (!rst_n)
      alu_done[i] == exp_alu_v[i])
      else report_mismatch($sformatf("alu_done[%0d]", i), $sampled(exp_alu_v[i]),
                           $sampled(alu_done[i]));
    alu_result_a: assert property (@(posedge clock) disable iff (!rst_n)
      exp_alu_v[i] |-> alu_result[i] == exp_alu_res[i])
      else report_mismatch($sformatf("alu_result[%0d]", i), $sampled(exp_alu_res[i]),
                           $sampled(alu_result[i]));
    alu_tag_a: assert property (@(posedge clock) disable iff (!rst_n)
      exp_alu_v[i] |-> alu_done_tag[i] == exp_alu_tag[i])
      else report_mismatch($sformatf("alu_done_tag[%0d]", i), $sampled(exp_alu_tag[i]),
                           $sampled(alu_done_tag[i]));
  end

  mult_done_a: assert property (@(posedge clock) disable iff (!rst_n)
    mult_done == exp_mult_v[mult_stages-1])
    else report_mismatch("mult_done", $sampled(exp_mult_v[mult_stages-1]), $sampled(mult_done));
  mult_result_a: assert property (@(posedge clock) disable iff (!rst_n)
    exp_mult_v[mult_stages-1] |-> mult_result == exp_mult_res[mult_stages-1])
    else report_mismatch("mult_result", $sampled(exp_mult_res[mult_stages-1]),
                         $sampled(mult_result));
  mult_tag_a: assert property (@(posedge clock) disable iff (!rst_n)
    exp_mult_v[mult_stages-1] |-> mult_done_tag == exp_mult_tag[mult_stages-1])
    else report_mismatch("mult_done_tag", $sampled(exp_mult_tag[mult_stages-1]),
                         $sampled(mult_done_tag));

  br_done_a: assert property (@(posedge clock) disable iff (!rst_n) br_done == exp_br_v)
    else report_mismatch("br_done", $sampled(exp_br_v), $sampled(br_done));
  br_taken_a: assert property (@(posedge clock) disable iff (!rst_n)
    exp_br_v |-> br_taken == exp_br_taken)
    else report_mismatch("br_taken", $sampled(exp_br_taken), $sampled(br_taken));
  br_tag_a: assert property (@(posedge clock) disable iff (!rst_n)
    exp_br_v |-> br_done_tag == exp_br_tag)
    else report_mismatch("br_done_tag", $sampled(exp_br_tag), $sampled(br_done_tag));
  br_mispredict_a: assert property (@(posedge clock) disable iff (!rst_n)
    br_mispredict == (exp_br_v && exp_br_mis))
    else report_mismatch("br_mispredict", $sampled(exp_br_v && exp_br_mis),
                         $sampled(br_mispredict));

  initial begin
    seed    = 19042;
    tag_seq = '0;
    rst_n   = 1'b0;
    clear_valids();
    for (int lane = 0; lane < num_alu; lane++) begin
      alu_func[lane] = fu_pkg::alu_addq;
      alu_opa[lane]  = '0;
      alu_opb[lane]  = '0;
      alu_tag[lane]  = '0;
    end
    mult_opa      = '0;
    mult_opb      = '0;
    mult_tag      = '0;
    br_func       = '0;
    br_opa        = '0;
    br_pred_taken = 1'b0;
    br_tag        = '0;
    repeat (16) @(posedge clock);
    #10;
    rst_n = 1'b1;

    // every operation on both lanes at once
    for (int op = 0; op < 16; op++) begin
      for (int r = 0; r < alu_reps; r++) begin
        drive_alu(0, fu_pkg::alu_func_t'(op), rand_word(), rand_word());
        drive_alu(1, fu_pkg::alu_func_t'((op + r) % 16), rand_word(), rand_word());
        next_drive_slot();
      end
    end

    // compare corners, lane 1 gets the swapped pair
    for (int a = 0; a < 5; a++) begin
      for (int b = 0; b < 5; b++) begin
        for (int k = 0; k < 5; k++) begin
          drive_alu(0, cmp_ops[k], corner_vals[a], corner_vals[b]);
          drive_alu(1, cmp_ops[k], corner_vals[b], corner_vals[a]);
          next_drive_slot();
        end
      end
    end

    for (int k = 0; k < 3; k++) begin
      for (int s = 0; s < 5; s++) begin
        for (int a = 0; a < 5; a++) begin
          drive_alu(0, shift_ops[k], corner_vals[a], shift_amts[s]);
          drive_alu(1, shift_ops[k], rand_word(), shift_amts[s]);
          next_drive_slot();
        end
      end
    end
    clear_valids();

    // back to back, so mult_stages products overlap
    for (int i = 0; i < n_mult; i++) begin
      case (i % 6)
        0:       drive_mult('1, '1);
        1:       drive_mult('1, rand_word());
        2:       drive_mult(rand_word(), '1);
        default: drive_mult(rand_word(), rand_word());
      endcase
      next_drive_slot();
    end
    clear_valids();

    for (int f = 0; f < 8; f++) begin
      for (int o = 0; o < 4; o++) begin
        for (int p = 0; p < 2; p++) begin
          drive_br(fu_pkg::br_func_t'(f),
                   (o == 3) ? (rand_word() | 64'h8000_0000_0000_0000) : fu_pkg::xword_t'(o),
                   p[0]);
          next_drive_slot();
        end
      end
    end
    clear_valids();

    repeat (n_idle) next_drive_slot();  // stale operands, no valid

    for (int c = 0; c < n_mixed; c++) begin
      for (int lane = 0; lane < num_alu; lane++) begin
        if (coin())
          drive_alu(lane, fu_pkg::alu_func_t'($unsigned($random(seed)) % 16),
                    rand_word(), rand_word());
        else
          alu_valid[lane] = 1'b0;
      end
      if (coin()) drive_mult(rand_word(), rand_word());
      else mult_valid = 1'b0;
      if (coin()) drive_br(fu_pkg::br_func_t'($random(seed)), rand_word(), coin());
      else br_valid = 1'b0;
      next_drive_slot();
    end
    clear_valids();

    repeat (mult_stages + 2) next_drive_slot();  // drain the multiplier
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("timeout: the test did not finish within %0d ns", timeout_ns);
    stop_with_failure();
  end

endmodule

// ==== flist.f ====
fu_pkg.sv
alu.sv
mult.sv
brcond.sv
fu_bank.sv
tb_fu_bank.sv

// ==== Bender.yml ====
package:
  name: fu_bank

sources:
  - fu_pkg.sv
  - alu.sv
  - mult.sv
  - brcond.sv
  - fu_bank.sv
  - target: test
    files:
      - tb_fu_bank.sv
